// ==== verilog/fp_convert_pkg.sv ====
`default_nettype none

package fp_convert_pkg;

    // binary32 layout.
    localparam int word_width = 32;
    localparam int exp_width  = 8;
    localparam int man_width  = 23;
    localparam int exp_bias   = 127;

    // largest unbiased exponent whose integer part fits in 31 bits.
    localparam int max_shift = word_width - 2;

    // biased exponent for a leading one at bit 31.
    localparam int int_exp_top = exp_bias + word_width - 1;

    // stages in each converter.
    localparam int pipe_depth = 3;

    typedef enum logic
    {
        op_fptosi = 1'b0, // float to signed int.
        op_sitofp = 1'b1  // signed int to float.
    } conv_op_t;

endpackage

`default_nettype wire

// ==== verilog/lead_zero_count.sv ====
`timescale 1ns/1ps
`default_nettype none

module lead_zero_count
(
    input  wire  [fp_convert_pkg::word_width-1:0] value,
    output logic [5:0]                            count
);
    import fp_convert_pkg::*;

    // binary search over halves, quarters and so on.
    logic [word_width-1:0] v16;
    logic [word_width-1:0] v8;
    logic [word_width-1:0] v4;
    logic [word_width-1:0] v2;
    logic z16;
    logic z8;
    logic z4;
    logic z2;
    logic z1;
    logic all_zero;

    always_comb
    begin
        z16 = (value[31:16] == 16'd0);
        v16 = z16 ? {value[15:0], 16'd0} : value;

        z8 = (v16[31:24] == 8'd0);
        v8 = z8 ? {v16[23:0], 8'd0} : v16;

        z4 = (v8[31:28] == 4'd0);
        v4 = z4 ? {v8[27:0], 4'd0} : v8;

        z2 = (v4[31:30] == 2'd0);
        v2 = z2 ? {v4[29:0], 2'd0} : v4;

        z1 = ~v2[31]; // one last position to go.

        all_zero = (value == '0);
    end

    // each zero flag adds its weight to the count.
    always_comb
    begin
        if (all_zero)
            count = 6'(word_width);
        else
            count = {1'b0, z16, z8, z4, z2, z1};
    end

endmodule

`default_nettype wire

// ==== verilog/fp_to_int.sv ====
`timescale 1ns/1ps
`default_nettype none

module fp_to_int
(
    input  wire                                   clock,
    input  wire                                   resetn,
    input  wire                                   enable,
    input  wire  [fp_convert_pkg::word_width-1:0] dataa,
    output logic [fp_convert_pkg::word_width-1:0] result
);
    import fp_convert_pkg::*;

    // field split of the input word.
    logic                 sign_0;
    logic [exp_width-1:0] exp_0;
    logic [man_width-1:0] man_0;

    assign sign_0 = dataa[word_width-1];
    assign exp_0  = dataa[word_width-2 -: exp_width];
    assign man_0  = dataa[man_width-1:0];

    // stage 1 registers.
    logic                  sign_1;
    logic [word_width-2:0] man_1;
    logic [exp_width-1:0]  shift_1;

    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
        begin
            sign_1  <= 1'b0;
            man_1   <= '0;
            shift_1 <= '0;
        end
        else if (enable)
        begin
            sign_1 <= sign_0;
            if (exp_0 < exp_width'(exp_bias))
            begin
                man_1   <= '0; // |x| < 1.
                shift_1 <= '0;
            end
            else
            begin
                // implied one at bit 30.
                man_1   <= {1'b1, man_0, (word_width - 2 - man_width)'(0)};
                shift_1 <= exp_0 - exp_width'(exp_bias);
            end
        end
    end

    // stage 2 registers.
    logic                  sign_2;
    logic [word_width-2:0] mag_2;

    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
        begin
            sign_2 <= 1'b0;
            mag_2  <= '0;
        end
        else if (enable)
        begin
            sign_2 <= sign_1;
            if (shift_1 > exp_width'(max_shift))
                mag_2 <= '1; // too large, inf and nan too.
            else
                mag_2 <= man_1 >> (exp_width'(max_shift) - shift_1);
        end
    end

    // stage 3 applies the sign.
    logic [word_width-1:0] result_3;

    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
            result_3 <= '0;
        else if (enable)
        begin
            if (sign_2)
                result_3 <= ~{1'b0, mag_2} + word_width'(1);
            else
                result_3 <= {1'b0, mag_2};
        end
    end

    assign result = result_3;

endmodule

`default_nettype wire

// ==== verilog/int_to_fp.sv ====
`timescale 1ns/1ps
`default_nettype none

module int_to_fp
(
    input  wire                                   clock,
    input  wire                                   resetn,
    input  wire                                   enable,
    input  wire  [fp_convert_pkg::word_width-1:0] dataa,
    output logic [fp_convert_pkg::word_width-1:0] result
);
    import fp_convert_pkg::*;

    // stage 1 registers sign and magnitude.
    logic                  sign_1;
    logic [word_width-1:0] mag_1;

    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
        begin
            sign_1 <= 1'b0;
            mag_1  <= '0;
        end
        else if (enable)
        begin
            sign_1 <= dataa[word_width-1];
            // 32'h8000_0000 maps onto itself, still correct unsigned.
            mag_1 <= dataa[word_width-1] ? (~dataa + word_width'(1)) : dataa;
        end
    end

    // normalization.
    logic [5:0] lz_count;

    lead_zero_count lead_zero_count_i
    (
        .value (mag_1),
        .count (lz_count)
    );

    logic                  sign_2;
    logic [word_width-1:0] norm_2;
    logic [exp_width-1:0]  exp_2;
    logic                  zero_2;

    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
        begin
            sign_2 <= 1'b0;
            norm_2 <= '0;
            exp_2  <= '0;
            zero_2 <= 1'b0;
        end
        else if (enable)
        begin
            sign_2 <= sign_1;
            norm_2 <= mag_1 << lz_count;    // leading one to bit 31.
            exp_2  <= exp_width'(int_exp_top) - exp_width'(lz_count);
            zero_2 <= (lz_count == 6'(word_width));
        end
    end

    // round to nearest even on the bits below the mantissa.
    logic [man_width-1:0] mant;
    logic                 guard;
    logic                 sticky;
    logic                 round_up;
    logic [man_width:0]   mant_rnd;
    logic [exp_width-1:0] exp_rnd;

    always_comb
    begin
        mant     = norm_2[word_width-2 -: man_width];
        guard    = norm_2[word_width-2-man_width];
        sticky   = |norm_2[word_width-3-man_width:0];
        round_up = guard & (sticky | mant[0]);
        mant_rnd = {1'b0, mant} + (man_width + 1)'(round_up);
        // carry out means 2.0, mantissa wraps to zero.
        exp_rnd  = exp_2 + exp_width'(mant_rnd[man_width]);
    end

    logic [word_width-1:0] result_3;

    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
            result_3 <= '0;
        else if (enable)
        begin
            if (zero_2)
                result_3 <= '0; // +0.0.
            else
                result_3 <= {sign_2, exp_rnd, mant_rnd[man_width-1:0]};
        end
    end

    assign result = result_3;

endmodule

`default_nettype wire

// ==== verilog/fp_convert.sv ====
`timescale 1ns/1ps
`default_nettype none

module fp_convert
(
    input  wire                                   clock,
    input  wire                                   resetn,
    input  wire                                   enable,
    input  wire                                   valid,
    input  wire  fp_convert_pkg::conv_op_t        op,
    input  wire  [fp_convert_pkg::word_width-1:0] operand,
    output logic [fp_convert_pkg::word_width-1:0] result,
    output logic                                  result_valid
);
    import fp_convert_pkg::*;

    logic [word_width-1:0] fptosi_result;
    logic [word_width-1:0] sitofp_result;

    // both converters see every operand.
    fp_to_int fp_to_int_i
    (
        .clock  (clock),
        .resetn (resetn),
        .enable (enable),
        .dataa  (operand),
        .result (fptosi_result)
    );

    int_to_fp int_to_fp_i
    (
        .clock  (clock),
        .resetn (resetn),
        .enable (enable),
        .dataa  (operand),
        .result (sitofp_result)
    );

    // opcode and valid ride along with the data.
    conv_op_t              op_pipe [pipe_depth];
    logic [pipe_depth-1:0] valid_pipe;

    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
        begin
            for (int i = 0; i < pipe_depth; i++)
            begin
                op_pipe[i] <= op_fptosi;
            end
            valid_pipe <= '0;
        end
        else if (enable)
        begin
            op_pipe[0] <= op;
            for (int i = 1; i < pipe_depth; i++)
            begin
                op_pipe[i] <= op_pipe[i-1];
            end
            valid_pipe <= {valid_pipe[pipe_depth-2:0], valid};
        end
    end

    // converter outputs are registered so the mux holds during a stall.
    always_comb
    begin
        if (op_pipe[pipe_depth-1] == op_sitofp)
            result = sitofp_result;
        else
            result = fptosi_result;
    end

    assign result_valid = valid_pipe[pipe_depth-1];

endmodule

`default_nettype wire

// ==== test/fp_convert_model.svh ====
`ifndef FP_CONVERT_MODEL_SVH
`define FP_CONVERT_MODEL_SVH

// float to signed int by truncation toward zero with a saturated magnitude.
function automatic logic [31:0] model_fptosi(input logic [31:0] a);
    int          e;
    logic [23:0] sig;
    logic [30:0] mag;

    e   = int'(a[30:23]) - 127;
    sig = {1'b1, a[22:0]};   // value is sig * 2^(e - 23).
    if (e < 0)
        mag = '0;
    else if (e > 30)
        mag = '1;
    else if (e >= 23)
        mag = 31'(sig) << (e - 23);
    else
        mag = 31'(sig >> (23 - e));
    if (a[31])
        return 32'd0 - {1'b0, mag};
    return {1'b0, mag};
endfunction

// signed int to float with round to nearest even.
function automatic logic [31:0] model_sitofp(input logic [31:0] a);
    logic [31:0] mag;
    logic [31:0] norm;
    logic [23:0] frac;
    logic        rnd;
    int          msb;
    logic [7:0]  e;

    if (a == 32'd0)
        return 32'h0000_0000;
    mag = a[31] ? (~a + 32'd1) : a;

    // find the leading one by scanning down.
    msb = 31;
    while (!mag[msb])
        msb--;
    norm = mag << (31 - msb);

    frac = {1'b0, norm[30:8]};
    rnd  = norm[7] && ((|norm[6:0]) || norm[8]);
    frac = frac + 24'(rnd);
    e    = 8'(127 + msb) + 8'(frac[23]);
    return {a[31], e, frac[22:0]};
endfunction

`endif

// ==== test/tb_fp_convert.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_fp_convert;
    import fp_convert_pkg::*;

    `include "fp_convert_model.svh"

    logic        clock;
    logic        resetn;
    logic        enable;
    logic        valid;
    conv_op_t    op;
    logic [31:0] operand;
    logic [31:0] result;
    logic        result_valid;

    fp_convert fp_convert_i
    (
        .clock        (clock),
        .resetn       (resetn),
        .enable       (enable),
        .valid        (valid),
        .op           (op),
        .operand      (operand),
        .result       (result),
        .result_valid (result_valid)
    );

    always #10 clock = ~clock;

    // stimulus table.
    string       tbl_name[$];
    conv_op_t    tbl_op[$];
    logic [31:0] tbl_operand[$];
    logic [31:0] tbl_expect[$];

    // scoreboard, one entry per issued operand.
    logic [31:0] expect_q[$];
    string       name_q[$];
    int          issue_q[$];

    int          error_count;
    int          check_count;
    int          en_count;     // rising edges seen with enable high.
    logic        prev_valid;
    logic [31:0] prev_result;
    logic [31:0] rng;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        check_count++;
        if (expected !== actual)
        begin
            $display("mismatch %s: expected %08h, actual %08h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic add_entry(input string name, input conv_op_t o,
                             input logic [31:0] x, input logic [31:0] expected);
        tbl_name.push_back(name);
        tbl_op.push_back(o);
        tbl_operand.push_back(x);
        tbl_expect.push_back(expected);
    endtask

    task automatic load_table;
        add_entry("fptosi 1.0",       op_fptosi, 32'h3f80_0000, 32'h0000_0001);
        add_entry("fptosi -1.0",      op_fptosi, 32'hbf80_0000, 32'hffff_ffff);
        add_entry("fptosi 0.75",      op_fptosi, 32'h3f40_0000, 32'h0000_0000);
        add_entry("fptosi 123.9",     op_fptosi, 32'h42f7_cccd, 32'h0000_007b);
        add_entry("fptosi -2.5e9",    op_fptosi, 32'hcf15_02f9, 32'h8000_0001);
        add_entry("fptosi +inf",      op_fptosi, 32'h7f80_0000, 32'h7fff_ffff);
        add_entry("fptosi nan",       op_fptosi, 32'h7fc0_0000, 32'h7fff_ffff);
        add_entry("fptosi 2^30",      op_fptosi, 32'h4e80_0000, 32'h4000_0000);
        add_entry("sitofp 0",         op_sitofp, 32'h0000_0000, 32'h0000_0000);
        add_entry("sitofp 1",         op_sitofp, 32'h0000_0001, 32'h3f80_0000);
        add_entry("sitofp -1",        op_sitofp, 32'hffff_ffff, 32'hbf80_0000);
        add_entry("sitofp int max",   op_sitofp, 32'h7fff_ffff, 32'h4f00_0000);
        add_entry("sitofp int min",   op_sitofp, 32'h8000_0000, 32'hcf00_0000);
        add_entry("sitofp 16777217",  op_sitofp, 32'd16777217,  32'h4b80_0000);
        add_entry("sitofp 16777219",  op_sitofp, 32'd16777219,  32'h4b80_0002);
    endtask

    // one clock, observing outputs at the falling edge before new inputs go out.
    task automatic next_cycle;
        logic [31:0] exp_val;
        string       exp_name;
        int          issued;
        @(negedge clock);
        if (enable)
            en_count++;
        if (!enable)
        begin
            check("stall hold result_valid", 32'(prev_valid), 32'(result_valid));
            check("stall hold result", prev_result, result);
        end
        else if (result_valid)
        begin
            if (expect_q.size() == 0)
            begin
                $display("error: result_valid high with no operand outstanding at %0t",
                         $time);
                error_count++;
            end
            else
            begin
                exp_val  = expect_q.pop_front();
                exp_name = name_q.pop_front();
                issued   = issue_q.pop_front();
                check(exp_name, exp_val, result);
                check($sformatf("%s latency", exp_name), 32'(pipe_depth),
                      32'(en_count - issued));
            end
        end
        prev_valid  = result_valid;
        prev_result = result;
    endtask

    task automatic issue(input string name, input conv_op_t o,
                         input logic [31:0] x, input logic [31:0] expected);
        enable  = 1'b1;
        valid   = 1'b1;
        op      = o;
        operand = x;
        expect_q.push_back(expected);
        name_q.push_back(name);
        issue_q.push_back(en_count);
        next_cycle();
    endtask

    task automatic bubble;
        enable = 1'b1;
        valid  = 1'b0;
        next_cycle();
    endtask

    // valid stays high, it must be ignored while enable is low.
    task automatic stall(input int cycles);
        enable = 1'b0;
        valid  = 1'b1;
        repeat (cycles) next_cycle();
    endtask

    task automatic drain;
        int timeout;
        enable  = 1'b1;
        valid   = 1'b0;
        timeout = 0;
        while (expect_q.size() != 0 && timeout < 4 * pipe_depth)
        begin
            next_cycle();
            timeout++;
        end
        if (expect_q.size() != 0)
        begin
            $display("error: no result arrived for %0d issued operands within %0d cycles",
                     expect_q.size(), timeout);
            error_count++;
            expect_q.delete();
            name_q.delete();
            issue_q.delete();
        end
    endtask

    initial
    begin
        logic [31:0] r;
        logic [31:0] x;
        conv_op_t    rop;

        clock       = 1'b0;
        resetn      = 1'b0;
        enable      = 1'b0;
        valid       = 1'b0;
        op          = op_fptosi;
        operand     = '0;
        error_count = 0;
        check_count = 0;
        en_count    = 0;
        prev_valid  = 1'b0;
        prev_result = '0;
        rng         = 32'h2143_e7a1;

        repeat (2) @(posedge clock);
        @(negedge clock);
        resetn = 1'b1;
        enable = 1'b1;

        check("reset result_valid", 32'd0, 32'(result_valid));
        check("reset result", 32'd0, result);
        repeat (2) bubble();
        check("idle result_valid", 32'd0, 32'(result_valid));
        check("idle result", 32'd0, result);

        // directed cases, back to back.
        load_table();
        for (int i = 0; i < tbl_name.size(); i++)
            issue(tbl_name[i], tbl_op[i], tbl_operand[i], tbl_expect[i]);
        drain();

        // random mix with stalls and bubbles.
        for (int i = 0; i < 200; i++)
        begin
            if (i % 40 == 25)
            begin
                rng = xorshift32(rng);
                stall(1 + int'(rng[1:0]));
            end
            rng = xorshift32(rng);
            r   = rng;
            rng = xorshift32(rng);
            x   = rng;
            rop = conv_op_t'(r[0]);
            if (rop == op_sitofp)
                issue($sformatf("random %0d sitofp %08h", i, x), rop, x, model_sitofp(x));
            else
            begin
                if (r[1])
                    x[30:23] = 8'd120 + 8'(r[10:6]); // mostly in range.
                issue($sformatf("random %0d fptosi %08h", i, x), rop, x, model_fptosi(x));
            end
            if (r[5:2] == 4'd0)
                bubble();
        end
        drain();

        $display("errors: %0d, checks: %0d", error_count, check_count);
        if (error_count == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+test
verilog/fp_convert_pkg.sv
verilog/lead_zero_count.sv
verilog/fp_to_int.sv
verilog/int_to_fp.sv
verilog/fp_convert.sv
test/tb_fp_convert.sv

// ==== Bender.yml ====
package:
  name: fp_convert

sources:
  # rtl, in compile order
  - files:
      - verilog/fp_convert_pkg.sv
      - verilog/lead_zero_count.sv
      - verilog/fp_to_int.sv
      - verilog/int_to_fp.sv
      - verilog/fp_convert.sv

  # testbench
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_fp_convert.sv
